/* hdl/core_sizes_pkg.sv */
`default_nettype none

package core_sizes_pkg;

  // Register value
  localparam int data_width = 32;
  typedef logic [data_width-1:0] data_t;

  // Architectural registers, r0 always reads zero
  localparam int arch_regs = 16;
  typedef logic [$clog2(arch_regs)-1:0] arch_idx_t;

  // Physical registers
  localparam int phys_regs = 32;  // p0 is the permanent zero register
  typedef logic [$clog2(phys_regs)-1:0] phys_idx_t;

  // Reorder buffer slot, bounds rob_depth to 8
  typedef logic [2:0] rob_idx_t;

endpackage

`default_nettype wire

/* hdl/isa_pkg.sv */
`default_nettype none

package isa_pkg;

  typedef enum logic [3:0] {
    op_add = 4'd0,
    op_sub = 4'd1,
    op_and = 4'd2,
    op_or  = 4'd3,
    op_xor = 4'd4,
    op_shl = 4'd5,
    op_mul = 4'd6,
    op_ldi = 4'd7
  } opcode_t;

  // opcode | dest | src_a | src_b | imm
  typedef logic [23:0] inst_t;

  localparam int opcode_lsb = 20;
  localparam int dest_lsb   = 16;
  localparam int src_a_lsb  = 12;
  localparam int src_b_lsb  = 8;
  localparam int imm_lsb    = 0;

  // Single-cycle lane result, multiply has its own pipeline
  function automatic core_sizes_pkg::data_t alu_result(
    input opcode_t               op,
    input core_sizes_pkg::data_t a,
    input core_sizes_pkg::data_t b,
    input logic [7:0]            imm
  );
    core_sizes_pkg::data_t result;
    case (op)
      op_add:  result = a + b;
      op_sub:  result = a - b;
      op_and:  result = a & b;
      op_or:   result = a | b;
      op_xor:  result = a ^ b;
      op_shl:  result = a << b[4:0];
      op_ldi:  result = core_sizes_pkg::data_t'(imm);  // Zero-extended
      default: result = '0;
    endcase
    return result;
  endfunction

endpackage

`default_nettype wire

/* hdl/rename_table.sv */
`timescale 1ns/1ps
`default_nettype none

module rename_table (
  input  logic                      clock,
  input  logic                      reset,
  input  logic                      dispatch,
  input  core_sizes_pkg::arch_idx_t src_a,
  input  core_sizes_pkg::arch_idx_t src_b,
  input  core_sizes_pkg::arch_idx_t dest,
  input  logic                      alu_valid,
  input  core_sizes_pkg::phys_idx_t alu_tag,
  input  logic                      mul_valid,
  input  core_sizes_pkg::phys_idx_t mul_tag,
  input  logic                      free_valid,
  input  core_sizes_pkg::phys_idx_t free_tag,
  output core_sizes_pkg::phys_idx_t tag_a,
  output core_sizes_pkg::phys_idx_t tag_b,
  output logic                      ready_a,
  output logic                      ready_b,
  output core_sizes_pkg::phys_idx_t new_tag,
  output core_sizes_pkg::phys_idx_t old_tag,
  output logic                      free_empty
);

  import core_sizes_pkg::*;

  phys_idx_t            map [arch_regs];
  logic [phys_regs-1:0] free_bits;
  logic [phys_regs-1:0] ready;
  phys_idx_t            pick;

  // Lowest free register wins
  always_comb
  begin
    pick = '0;
    for (int i = phys_regs - 1; i > 0; i--)
    begin
      if (free_bits[i])
        pick = phys_idx_t'(i);
    end
  end

  assign tag_a      = map[src_a];
  assign tag_b      = map[src_b];
  assign new_tag    = (dest == '0) ? '0 : pick;  // r0 never allocates
  assign old_tag    = map[dest];
  assign free_empty = (free_bits == '0);

  // Result bus counts as ready in the cycle it is written
  assign ready_a = ready[tag_a] || (alu_valid && alu_tag == tag_a) ||
                   (mul_valid && mul_tag == tag_a);
  assign ready_b = ready[tag_b] || (alu_valid && alu_tag == tag_b) ||
                   (mul_valid && mul_tag == tag_b);

  always_ff @(posedge clock)
  begin
    if (reset)
    begin
      for (int i = 0; i < arch_regs; i++)
        map[i] <= phys_idx_t'(i);  // Identity map
      for (int i = 0; i < phys_regs; i++)
        free_bits[i] <= (i >= arch_regs);
      ready <= '1;
    end
    else
    begin
      if (dispatch && dest != '0)
      begin
        map[dest]       <= pick;
        free_bits[pick] <= 1'b0;
        ready[pick]     <= 1'b0;
      end
      if (free_valid)
        free_bits[free_tag] <= 1'b1;
      if (alu_valid)
        ready[alu_tag] <= 1'b1;
      if (mul_valid)
        ready[mul_tag] <= 1'b1;
    end
  end

endmodule

`default_nettype wire

/* hdl/issue_queue.sv */
`timescale 1ns/1ps
`default_nettype none

module issue_queue #(
  parameter int rs_depth = 4
) (
  input  logic                      clock,
  input  logic                      reset,
  input  logic                      dispatch,
  input  isa_pkg::opcode_t          opcode,
  input  logic [7:0]                imm,
  input  core_sizes_pkg::phys_idx_t tag_a,
  input  core_sizes_pkg::phys_idx_t tag_b,
  input  logic                      ready_a,
  input  logic                      ready_b,
  input  core_sizes_pkg::phys_idx_t dest_tag,
  input  core_sizes_pkg::rob_idx_t  rob_idx,
  input  logic                      alu_valid,
  input  core_sizes_pkg::phys_idx_t alu_tag,
  input  logic                      mul_valid,
  input  core_sizes_pkg::phys_idx_t mul_tag,
  output logic                      rs_full,
  output logic                      issue_valid,
  output isa_pkg::opcode_t          issue_op,
  output logic [7:0]                issue_imm,
  output core_sizes_pkg::phys_idx_t issue_tag_a,
  output core_sizes_pkg::phys_idx_t issue_tag_b,
  output core_sizes_pkg::phys_idx_t issue_dest,
  output core_sizes_pkg::rob_idx_t  issue_rob
);

  import core_sizes_pkg::*;
  import isa_pkg::*;

  localparam int idx_w = (rs_depth > 1) ? $clog2(rs_depth) : 1;

  logic [rs_depth-1:0] valid;
  logic [rs_depth-1:0] rdy_a;
  logic [rs_depth-1:0] rdy_b;
  opcode_t             op_q    [rs_depth];
  logic [7:0]          imm_q   [rs_depth];
  phys_idx_t           src_a_q [rs_depth];
  phys_idx_t           src_b_q [rs_depth];
  phys_idx_t           dest_q  [rs_depth];
  rob_idx_t            rob_q   [rs_depth];
  logic [idx_w-1:0]    age     [rs_depth];  // Number of older live entries
  logic                grant;
  logic [idx_w-1:0]    grant_idx;
  logic [idx_w-1:0]    slot_idx;
  logic [idx_w-1:0]    live;

  //////////////////////////////////////////////////
  // Free slot, occupancy and oldest-ready select
  always_comb
  begin
    grant     = 1'b0;
    grant_idx = '0;
    slot_idx  = '0;
    live      = '0;  // Wraps only when full, then nothing dispatches
    for (int i = rs_depth - 1; i >= 0; i--)
    begin
      if (!valid[i])
        slot_idx = idx_w'(i);
      else
        live = live + 1'b1;
    end
    for (int i = 0; i < rs_depth; i++)
    begin
      if (valid[i] && rdy_a[i] && rdy_b[i] && (!grant || age[i] < age[grant_idx]))
      begin
        grant     = 1'b1;
        grant_idx = idx_w'(i);
      end
    end
  end

  assign rs_full = &valid;

  always_ff @(posedge clock)
  begin
    if (reset)
    begin
      valid       <= '0;
      issue_valid <= 1'b0;
    end
    else
    begin
      issue_valid <= grant;
      if (grant)
        valid[grant_idx] <= 1'b0;
      if (dispatch)
        valid[slot_idx] <= 1'b1;
    end
  end

  //////////////////////////////////////////////////
  // Entry payload, wakeup and the issue register
  always_ff @(posedge clock)
  begin
    for (int i = 0; i < rs_depth; i++)
    begin
      if ((alu_valid && src_a_q[i] == alu_tag) || (mul_valid && src_a_q[i] == mul_tag))
        rdy_a[i] <= 1'b1;
      if ((alu_valid && src_b_q[i] == alu_tag) || (mul_valid && src_b_q[i] == mul_tag))
        rdy_b[i] <= 1'b1;
      if (grant && age[i] > age[grant_idx])
        age[i] <= age[i] - 1'b1;  // Close the gap behind the granted one
    end
    if (dispatch)
    begin
      op_q[slot_idx]    <= opcode;
      imm_q[slot_idx]   <= imm;
      src_a_q[slot_idx] <= tag_a;
      src_b_q[slot_idx] <= tag_b;
      rdy_a[slot_idx]   <= ready_a;
      rdy_b[slot_idx]   <= ready_b;
      dest_q[slot_idx]  <= dest_tag;
      rob_q[slot_idx]   <= rob_idx;
      age[slot_idx]     <= live - idx_w'(grant);  // Youngest
    end
    if (grant)
    begin
      issue_op    <= op_q[grant_idx];
      issue_imm   <= imm_q[grant_idx];
      issue_tag_a <= src_a_q[grant_idx];
      issue_tag_b <= src_b_q[grant_idx];
      issue_dest  <= dest_q[grant_idx];
      issue_rob   <= rob_q[grant_idx];
    end
  end

endmodule

`default_nettype wire

/* hdl/phys_regfile.sv */
`timescale 1ns/1ps
`default_nettype none

module phys_regfile (
  input  logic                      clock,
  input  logic                      reset,
  input  core_sizes_pkg::phys_idx_t read_a,
  input  core_sizes_pkg::phys_idx_t read_b,
  input  core_sizes_pkg::phys_idx_t read_c,
  input  logic                      alu_valid,
  input  core_sizes_pkg::phys_idx_t alu_tag,
  input  core_sizes_pkg::data_t     alu_value,
  input  logic                      mul_valid,
  input  core_sizes_pkg::phys_idx_t mul_tag,
  input  core_sizes_pkg::data_t     mul_value,
  output core_sizes_pkg::data_t     value_a,
  output core_sizes_pkg::data_t     value_b,
  output core_sizes_pkg::data_t     value_c
);

  import core_sizes_pkg::*;

  data_t regs [phys_regs];

  // Same-cycle write bypass, p0 stays zero
  function automatic data_t read_port(input phys_idx_t tag);
    data_t value;
    if (tag == '0)
      value = '0;
    else if (alu_valid && alu_tag == tag)
      value = alu_value;
    else if (mul_valid && mul_tag == tag)
      value = mul_value;
    else
      value = regs[tag];
    return value;
  endfunction

  always_comb
  begin
    value_a = read_port(read_a);
    value_b = read_port(read_b);
    value_c = read_port(read_c);  // Commit data
  end

  always_ff @(posedge clock)
  begin
    if (reset)
    begin
      for (int i = 0; i < phys_regs; i++)
        regs[i] <= '0;  // Architectural state starts at zero
    end
    else
    begin
      if (alu_valid && alu_tag != '0)
        regs[alu_tag] <= alu_value;
      if (mul_valid && mul_tag != '0)
        regs[mul_tag] <= mul_value;
    end
  end

endmodule

`default_nettype wire

/* hdl/exec_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module exec_unit #(
  parameter int mul_stages = 3
) (
  input  logic                      clock,
  input  logic                      reset,
  input  logic                      issue_valid,
  input  isa_pkg::opcode_t          issue_op,
  input  logic [7:0]                issue_imm,
  input  core_sizes_pkg::data_t     value_a,
  input  core_sizes_pkg::data_t     value_b,
  input  core_sizes_pkg::phys_idx_t issue_dest,
  input  core_sizes_pkg::rob_idx_t  issue_rob,
  output logic                      alu_valid,
  output core_sizes_pkg::phys_idx_t alu_tag,
  output core_sizes_pkg::data_t     alu_value,
  output core_sizes_pkg::rob_idx_t  alu_rob,
  output logic                      mul_valid,
  output core_sizes_pkg::phys_idx_t mul_tag,
  output core_sizes_pkg::data_t     mul_value,
  output core_sizes_pkg::rob_idx_t  mul_rob
);

  import core_sizes_pkg::*;
  import isa_pkg::*;

  logic                  is_mul;
  logic [mul_stages-1:0] mv;
  phys_idx_t             mtag [mul_stages];
  rob_idx_t              mrob [mul_stages];
  data_t                 mval [mul_stages];

  assign is_mul = (issue_op == op_mul);

  always_ff @(posedge clock)
  begin
    if (reset)
    begin
      alu_valid <= 1'b0;
      mv        <= '0;
    end
    else
    begin
      alu_valid <= issue_valid && !is_mul;
      mv[0]     <= issue_valid && is_mul;
      for (int i = 1; i < mul_stages; i++)
        mv[i] <= mv[i-1];
    end
  end

  always_ff @(posedge clock)
  begin
    if (issue_valid && !is_mul)
    begin
      alu_tag   <= issue_dest;
      alu_rob   <= issue_rob;
      alu_value <= alu_result(issue_op, value_a, value_b, issue_imm);
    end
    mtag[0] <= issue_dest;
    mrob[0] <= issue_rob;
    mval[0] <= value_a * value_b;  // Low 32 bits of the product
    for (int i = 1; i < mul_stages; i++)
    begin
      mtag[i] <= mtag[i-1];
      mrob[i] <= mrob[i-1];
      mval[i] <= mval[i-1];
    end
  end

  assign mul_valid = mv[mul_stages-1];
  assign mul_tag   = mtag[mul_stages-1];
  assign mul_rob   = mrob[mul_stages-1];
  assign mul_value = mval[mul_stages-1];

endmodule

`default_nettype wire

/* hdl/reorder_buffer.sv */
`timescale 1ns/1ps
`default_nettype none

module reorder_buffer #(
  parameter int rob_depth = 8
) (
  input  logic                      clock,
  input  logic                      reset,
  input  logic                      dispatch,
  input  core_sizes_pkg::arch_idx_t dest,
  input  core_sizes_pkg::phys_idx_t new_tag,
  input  core_sizes_pkg::phys_idx_t old_tag,
  input  logic                      alu_valid,
  input  core_sizes_pkg::rob_idx_t  alu_rob,
  input  logic                      mul_valid,
  input  core_sizes_pkg::rob_idx_t  mul_rob,
  output logic                      rob_full,
  output core_sizes_pkg::rob_idx_t  alloc_idx,
  output logic                      commit_valid,
  output core_sizes_pkg::arch_idx_t commit_reg,
  output logic                      commit_wr_en,
  output core_sizes_pkg::phys_idx_t commit_tag,
  output logic                      free_valid,
  output core_sizes_pkg::phys_idx_t free_tag
);

  import core_sizes_pkg::*;

  localparam int       cnt_w = $clog2(rob_depth + 1);
  localparam rob_idx_t last  = rob_idx_t'(rob_depth - 1);

  arch_idx_t            dest_q [rob_depth];
  phys_idx_t            new_q  [rob_depth];
  phys_idx_t            old_q  [rob_depth];
  logic [rob_depth-1:0] done;
  rob_idx_t             head;
  rob_idx_t             tail;
  logic [cnt_w-1:0]     count;
  logic                 retire;

  assign retire       = (count != '0) && done[head];
  assign commit_valid = retire;
  assign commit_reg   = dest_q[head];
  assign commit_wr_en = retire && (dest_q[head] != '0);
  assign commit_tag   = new_q[head];
  assign free_valid   = retire && (old_q[head] != '0);  // Previous mapping is dead now
  assign free_tag     = old_q[head];
  assign alloc_idx    = tail;
  assign rob_full     = (count == cnt_w'(rob_depth));

  always_ff @(posedge clock)
  begin
    if (reset)
    begin
      head  <= '0;
      tail  <= '0;
      count <= '0;
      done  <= '0;
    end
    else
    begin
      if (dispatch)
      begin
        done[tail] <= 1'b0;
        tail       <= (tail == last) ? '0 : tail + 1'b1;
      end
      if (alu_valid)
        done[alu_rob] <= 1'b1;
      if (mul_valid)
        done[mul_rob] <= 1'b1;
      if (retire)
        head <= (head == last) ? '0 : head + 1'b1;
      count <= count + cnt_w'(dispatch) - cnt_w'(retire);
    end
  end

  always_ff @(posedge clock)
  begin
    if (dispatch)
    begin
      dest_q[tail] <= dest;
      new_q[tail]  <= new_tag;
      old_q[tail]  <= old_tag;
    end
  end

endmodule

`default_nettype wire

/* hdl/ooo_core.sv */
`timescale 1ns/1ps
`default_nettype none

module ooo_core #(
  parameter int rob_depth  = 8,
  parameter int rs_depth   = 4,
  parameter int mul_stages = 3
) (
  input  logic                      clock,
  input  logic                      reset,
  input  logic                      inst_valid,
  input  isa_pkg::inst_t            inst,
  output logic                      dispatch_stall,
  output logic                      commit_valid,
  output core_sizes_pkg::arch_idx_t commit_reg,
  output logic                      commit_wr_en,
  output core_sizes_pkg::data_t     commit_data
);

  import core_sizes_pkg::*;
  import isa_pkg::*;

  opcode_t    opcode;
  arch_idx_t  dest, src_a, src_b;
  logic [7:0] imm;
  logic       dispatch;
  phys_idx_t  tag_a, tag_b, new_tag, old_tag;  // Rename
  logic       ready_a, ready_b, free_empty;
  logic       rob_full, free_valid;
  rob_idx_t   alloc_idx;
  phys_idx_t  commit_tag, free_tag;
  logic       rs_full, issue_valid;
  opcode_t    issue_op;
  logic [7:0] issue_imm;
  phys_idx_t  issue_tag_a, issue_tag_b, issue_dest;
  rob_idx_t   issue_rob;
  data_t      value_a, value_b;
  logic       alu_valid, mul_valid;  // Result bus
  phys_idx_t  alu_tag, mul_tag;
  data_t      alu_value, mul_value;
  rob_idx_t   alu_rob, mul_rob;

  //////////////////////////////////////////////////
  // Field split and dispatch
  assign opcode = opcode_t'(inst[opcode_lsb +: 4]);
  assign dest   = inst[dest_lsb +: 4];
  assign src_a  = inst[src_a_lsb +: 4];
  assign src_b  = inst[src_b_lsb +: 4];
  assign imm    = inst[imm_lsb +: 8];

  assign dispatch_stall = rob_full | rs_full | free_empty;
  assign dispatch       = inst_valid && !dispatch_stall;

  //////////////////////////////////////////////////
  // Blocks
  rename_table u_rename (.*);

  issue_queue #(.rs_depth(rs_depth)) u_rs (
    .dest_tag (new_tag),
    .rob_idx  (alloc_idx),
    .*
  );

  phys_regfile u_prf (
    .read_a  (issue_tag_a),
    .read_b  (issue_tag_b),
    .read_c  (commit_tag),
    .value_c (commit_data),
    .*
  );

  exec_unit #(.mul_stages(mul_stages)) u_exec (.*);

  reorder_buffer #(.rob_depth(rob_depth)) u_rob (.*);

endmodule

`default_nettype wire

/* bench/ooo_core_asserts.sv */
`timescale 1ns/1ps
`default_nettype none

module ooo_core_asserts #(
  parameter int rob_depth = 8,
  parameter int map_w     = core_sizes_pkg::arch_regs * $bits(core_sizes_pkg::phys_idx_t)
) (
  input logic                      clock,
  input logic                      reset,
  input logic [3:0]                count,
  input logic                      commit_valid,
  input logic                      alloc,
  input core_sizes_pkg::phys_idx_t alloc_tag,
  input logic [map_w-1:0]          map_bits
);

  import core_sizes_pkg::*;

  localparam int tag_w = $bits(phys_idx_t);

  logic tag_mapped;

  // Some architectural register still names the new tag
  always_comb
  begin
    tag_mapped = 1'b0;
    for (int i = 0; i < arch_regs; i++)
    begin
      if (map_bits[i*tag_w +: tag_w] == alloc_tag)
        tag_mapped = 1'b1;
    end
  end

  count_in_range: assert property (@(posedge clock) disable iff (reset) count <= rob_depth)
    else $error("reorder buffer count %0d is above its depth %0d", count, rob_depth);

  // Registers are cleared by the reset edge
  quiet_after_reset: assert property (@(posedge clock) reset |=> !commit_valid)
    else $error("commit_valid rose while the core was held in reset");

  fresh_tag: assert property (@(posedge clock) disable iff (reset) alloc |-> !tag_mapped)
    else $error("dispatch handed out physical register %0d while it was in use", alloc_tag);

endmodule

bind reorder_buffer ooo_core_asserts #(.rob_depth(rob_depth)) rob_checks_i (
  .clock        (clock),
  .reset        (reset),
  .count        (count),
  .commit_valid (commit_valid),
  .alloc        (1'b0),
  .alloc_tag    ('0),
  .map_bits     ('0)
);

bind rename_table ooo_core_asserts rename_checks_i (
  .clock        (clock),
  .reset        (reset),
  .count        (4'd0),
  .commit_valid (1'b0),
  .alloc        (dispatch && dest != '0),
  .alloc_tag    (new_tag),
  .map_bits     ({map[15], map[14], map[13], map[12], map[11], map[10], map[9], map[8],
                  map[7], map[6], map[5], map[4], map[3], map[2], map[1], map[0]})
);

`default_nettype wire

/* bench/ooo_core_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module ooo_core_tb;

  import core_sizes_pkg::*;
  import isa_pkg::*;

  localparam int prog_len       = 300;
  localparam int mul_stages     = 3;
  localparam int reset_cycles   = 8;
  localparam int quiet_cycles   = 20;
  localparam int timeout_cycles = prog_len * (mul_stages + 8) + 200;

  logic      clock;
  logic      reset;
  logic      inst_valid;
  inst_t     inst;
  logic      dispatch_stall;
  logic      commit_valid;
  arch_idx_t commit_reg;
  logic      commit_wr_en;
  data_t     commit_data;

  inst_t     prog      [prog_len];
  arch_idx_t exp_reg   [prog_len];
  logic      exp_wr    [prog_len];
  data_t     exp_value [prog_len];
  int        commit_count;
  int        stall_cycles;
  int        cycle_count;

  ooo_core #(.mul_stages(mul_stages)) dut_i (.*);

  always #4 clock = ~clock;

  //////////////////////////////////////////////////
  // Reference model

  // Architectural result rules
  function automatic data_t expected_result(input opcode_t op, input data_t a, input data_t b,
                                            input logic [7:0] imm);
    data_t r;
    case (op)
      op_add:  r = a + b;
      op_sub:  r = a - b;
      op_and:  r = a & b;
      op_or:   r = a | b;
      op_xor:  r = a ^ b;
      op_shl:  r = a << b[4:0];
      op_mul:  r = a * b;  // Low 32 bits only
      op_ldi:  r = {24'd0, imm};
      default: r = '0;
    endcase
    return r;
  endfunction

  task automatic build_program();
    opcode_t   alu_ops [6] = '{op_add, op_sub, op_and, op_or, op_xor, op_shl};
    opcode_t   op;
    arch_idx_t dest;
    arch_idx_t src_a;
    arch_idx_t src_b;
    arch_idx_t last_dest;
    int        pick;
    last_dest = 4'd1;
    for (int i = 0; i < prog_len; i++)
    begin
      pick  = int'($urandom_range(99));
      dest  = arch_idx_t'($urandom_range(15));
      src_a = ($urandom_range(1) == 0) ? last_dest : arch_idx_t'($urandom_range(15));
      src_b = ($urandom_range(3) == 0) ? last_dest : arch_idx_t'($urandom_range(15));
      if (i % 60 >= 40 && i % 60 < 52)
      begin
        op    = op_mul;  // Dependent multiply chain, fills the RS
        src_a = last_dest;
        dest  = arch_idx_t'($urandom_range(15, 1));
      end
      else if (pick < 35)
        op = op_mul;
      else if (pick < 55)
        op = op_ldi;
      else
        op = alu_ops[$urandom_range(5)];
      prog[i]   = {op, dest, src_a, src_b, 8'($urandom_range(255))};
      last_dest = dest;
    end
  endtask

  // In-order run over 16 architectural registers
  task automatic build_expected();
    data_t     arch [arch_regs];
    arch_idx_t d;
    data_t     value;
    for (int r = 0; r < arch_regs; r++)
      arch[r] = '0;
    for (int i = 0; i < prog_len; i++)
    begin
      d     = prog[i][19:16];
      value = expected_result(opcode_t'(prog[i][23:20]), arch[prog[i][15:12]],
                              arch[prog[i][11:8]], prog[i][7:0]);
      exp_reg[i]   = d;
      exp_wr[i]    = (d != '0);
      exp_value[i] = (d != '0) ? value : '0;  // r0 reads back zero
      if (d != '0)
        arch[d] = value;
    end
  endtask

  //////////////////////////////////////////////////
  // Failure reporting

  task automatic fail_run(input string why);
    $display("%s", why);
    $display("test failed");
    $fatal(1, "simulation stopped on the first failure");
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] expected);
    if (got !== expected)
      fail_run($sformatf("Error at %0t: %s is 0x%0h, expected 0x%0h",
                         $time, name, got, expected));
  endtask

  //////////////////////////////////////////////////
  // Stimulus and end of run
  initial
  begin
    int idx;
    clock        = 1'b0;
    reset        = 1'b1;
    inst_valid   = 1'b0;
    inst         = '0;
    commit_count = 0;
    stall_cycles = 0;
    cycle_count  = 0;
    $timeformat(-9, 1, " ns", 0);
    void'($urandom(32'h72ad));
    build_program();
    build_expected();

    repeat (reset_cycles)
    begin
      @(negedge clock);
      check_value("commit_valid", 32'(commit_valid), 32'd0);
      check_value("dispatch_stall", 32'(dispatch_stall), 32'd0);
    end
    reset = 1'b0;
    @(negedge clock);
    check_value("commit_valid", 32'(commit_valid), 32'd0);  // First cycle out of reset
    check_value("dispatch_stall", 32'(dispatch_stall), 32'd0);

    idx = 0;
    while (idx < prog_len)
    begin
      inst_valid = 1'b1;
      inst       = prog[idx];
      if (dispatch_stall)
        stall_cycles++;  // Word held for another cycle
      else
        idx++;
      @(negedge clock);
    end
    inst_valid = 1'b0;

    while (commit_count < prog_len)
      @(posedge clock);
    repeat (quiet_cycles) @(posedge clock);  // Checker flags any stray commit

    if (stall_cycles > 0)
    begin
      $display("test passed");
      $finish;
    end
    else
      fail_run("dispatch_stall never rose, so back-pressure was not exercised");
  end

  // Commit outputs come from registers and settle before the falling edge
  always @(negedge clock)
  begin
    if (!reset && commit_valid)
    begin
      if (commit_count >= prog_len)
        fail_run("A commit arrived after every instruction had already retired");
      else
      begin
        check_value("commit_reg", 32'(commit_reg), 32'(exp_reg[commit_count]));
        check_value("commit_wr_en", 32'(commit_wr_en), 32'(exp_wr[commit_count]));
        check_value("commit_data", commit_data, exp_value[commit_count]);
        commit_count++;
      end
    end
  end

  always @(posedge clock)
  begin
    if (!reset)
    begin
      cycle_count++;
      if (cycle_count >= timeout_cycles)
        fail_run($sformatf("Timeout after %0d cycles with %0d of %0d instructions committed",
                           cycle_count, commit_count, prog_len));
    end
  end

endmodule

`default_nettype wire

/* filelist.f */
hdl/core_sizes_pkg.sv
hdl/isa_pkg.sv
hdl/rename_table.sv
hdl/issue_queue.sv
hdl/phys_regfile.sv
hdl/exec_unit.sv
hdl/reorder_buffer.sv
hdl/ooo_core.sv
bench/ooo_core_asserts.sv
bench/ooo_core_tb.sv

/* Makefile */
SRCS := $(shell cat filelist.f)

obj_dir/Vooo_core_tb: filelist.f $(SRCS)
	verilator --binary --assert -Wno-fatal --top-module ooo_core_tb -f filelist.f -o Vooo_core_tb

run: obj_dir/Vooo_core_tb
	./obj_dir/Vooo_core_tb

clean:
	rm -rf obj_dir

.PHONY: run clean
